//--- ccd_pkg.sv
// ==============================
// sensor pin bundle and scan line views
// pixel 0 is the first sample after SH, bit 0 of the line
// ==============================
`include "inspect_consts.svh"

package ccd_pkg;

	// pixels per LED zone
	localparam int ZONE_PIXELS = `SCAN_PIXELS / `LED_ZONES;

	// raw pins from the sensor board
	typedef struct packed {
		// shift gate, falling edge opens a frame
		logic sh;
		// master clock, both edges carry a pixel
		logic mclk;
		// serial video, already thresholded
		logic data;
	} ccd_pins_t;

	typedef logic [ZONE_PIXELS-1:0] zone_t;

	// one line, seen flat for compare and storage,
	// or split into zones for the LED bar
	typedef union packed {
		logic [`SCAN_PIXELS-1:0] flat;
		zone_t [`LED_ZONES-1:0] zones;
	} scan_line_u;

endpackage

//--- ccd_reader.sv
// ==============================
// pins are asynchronous, two-flop synced here
// mclk must toggle slower than CLOCK_50/2 for edges to be seen
// ==============================
`timescale 1ns/1ps
`include "inspect_consts.svh"

module ccd_reader (
	input  logic                CLOCK_50,
	input  logic                rst_n,
	input  ccd_pkg::ccd_pins_t  ccd,
	input  logic                scan_en,
	output ccd_pkg::scan_line_u line,
	output logic                line_valid
);
	import ccd_pkg::*;

	localparam int PW = $clog2(`SCAN_PIXELS);

	ccd_pins_t meta_q;
	ccd_pins_t sync_q;
	ccd_pins_t prev_q;
	logic sh_fall;
	logic mclk_edge;
	logic take;
	logic active_q;
	logic [PW-1:0] pix_q;
	scan_line_u shift_q;

	// ==============================
	// synchronizer and edge detect
	// ==============================
	always_ff @(posedge CLOCK_50) begin
		if (!rst_n) begin
			meta_q <= '0;
			sync_q <= '0;
			prev_q <= '0;
		end else begin
			meta_q <= ccd;
			sync_q <= meta_q;
			prev_q <= sync_q;
		end
	end

	assign sh_fall = prev_q.sh & ~sync_q.sh;
	// rising or falling, both clock a pixel
	assign mclk_edge = prev_q.mclk ^ sync_q.mclk;
	// data synced with mclk, so it lines up with the edge
	assign take = scan_en & active_q & mclk_edge & ~sh_fall;

	// ==============================
	// frame control
	// ==============================
	always_ff @(posedge CLOCK_50) begin
		if (!rst_n) begin
			active_q <= 1'b0;
			pix_q <= '0;
			line_valid <= 1'b0;
		end else begin
			line_valid <= 1'b0;
			if (!scan_en) begin
				// drop any half frame
				active_q <= 1'b0;
			end else if (sh_fall) begin
				active_q <= 1'b1;
				pix_q <= '0;
			end else if (take) begin
				pix_q <= pix_q + 1'b1;
				if (pix_q == PW'(`SCAN_PIXELS - 1)) begin
					active_q <= 1'b0;
					line_valid <= 1'b1;
				end
			end
		end
	end

	// shift right so the first pixel ends in bit 0
	always_ff @(posedge CLOCK_50) begin
		if (take) begin
			shift_q.flat <= {sync_q.data, shift_q.flat[`SCAN_PIXELS-1:1]};
		end
	end

	assign line = shift_q;

	// controller keeps scan_en up until it has taken the line
	a_valid_enabled: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
		line_valid |-> scan_en);

endmodule

//--- inspect_consts.svh
// ==============================
// sizes for the line-scan inspector
// DEBOUNCE_CYCLES is a simulation value, raise it for real buttons
// SCAN_PIXELS must divide evenly into LED_ZONES
// ==============================
`ifndef INSPECT_CONSTS_SVH
`define INSPECT_CONSTS_SVH

// ==============================
// sensor geometry
// ==============================

// pixels shifted out per SH frame
`define SCAN_PIXELS 64

// LED bar segments, each covers SCAN_PIXELS/LED_ZONES pixels
`define LED_ZONES 8

// ==============================
// storage and panel
// ==============================

// taught lines kept per profile
`define PROFILE_DEPTH 16

// cycles a button level has to hold
`define DEBOUNCE_CYCLES 4

`endif

//--- inspect_ctrl.sv
// ==============================
// part 0 teaches, every other part inspects
// each line is decided in the cycle of its line_valid
// ==============================
`timescale 1ns/1ps
`include "inspect_consts.svh"

module inspect_ctrl (
	input  logic                      CLOCK_50,
	input  logic                      rst_n,
	input  inspect_pkg::panel_cmd_t   cmd,
	input  ccd_pkg::scan_line_u       line,
	input  logic                      line_valid,
	input  ccd_pkg::scan_line_u       rdata,
	output logic                      scan_en,
	output logic                      count_en,
	output inspect_pkg::prof_addr_t   addr,
	output ccd_pkg::scan_line_u       wdata,
	output logic                      wr,
	output logic                      part_ok,
	output inspect_pkg::ctrl_status_t status
);
	import ccd_pkg::*;
	import inspect_pkg::*;

	inspect_state_e state_q;
	inspect_state_e state_d;
	part_num_t part_q;
	scan_line_u calib_q;
	prof_addr_t idx_q;
	logic ok_q;
	logic is_blank;
	logic teach_mode;
	logic in_run;
	logic part_line;
	logic room;

	// ==============================
	// line classification
	// ==============================

	// same as background, no part under the sensor
	assign is_blank = (line.flat == calib_q.flat);
	assign teach_mode = (part_q == '0);
	assign in_run = state_q inside {SEEK_TEACH, TEACH, SEEK_INSPECT, INSPECT};
	// a line that belongs to the part
	assign part_line = line_valid & in_run & ~is_blank;
	assign room = (idx_q < `PROFILE_DEPTH);

	// ==============================
	// run FSM
	// ==============================
	always_comb begin
		state_d = state_q;
		case (state_q)
			SELECT_PART: begin
				if (cmd.start) state_d = WAIT_START;
			end
			WAIT_START: begin
				if (cmd.start) state_d = CALIBRATE;
				else if (cmd.back) state_d = SELECT_PART;
			end
			CALIBRATE: begin
				if (line_valid) state_d = teach_mode ? SEEK_TEACH : SEEK_INSPECT;
			end
			SEEK_TEACH: begin
				if (part_line) state_d = TEACH;
			end
			SEEK_INSPECT: begin
				if (part_line) state_d = INSPECT;
			end
			TEACH, INSPECT: begin
				// part has passed
				if (line_valid && is_blank) state_d = SELECT_PART;
			end
			default: state_d = SELECT_PART;
		endcase
	end

	always_ff @(posedge CLOCK_50) begin
		if (!rst_n) begin
			state_q <= SELECT_PART;
			part_q <= '0;
			idx_q <= '0;
			ok_q <= 1'b0;
		end else begin
			state_q <= state_d;
			if (state_q == SELECT_PART && cmd.start) begin
				part_q <= cmd.count;
			end
			if (state_q == CALIBRATE && line_valid) begin
				idx_q <= '0;
				// inspection starts out good
				if (!teach_mode) ok_q <= 1'b1;
			end
			if (part_line) begin
				// saturate at a full profile
				if (room) idx_q <= idx_q + 1'b1;
				// lines past the profile have nothing to match
				if (!teach_mode && (!room || line.flat != rdata.flat)) ok_q <= 1'b0;
			end
		end
	end

	// background line, taken once per run
	always_ff @(posedge CLOCK_50) begin
		if (state_q == CALIBRATE && line_valid) begin
			calib_q <= line;
		end
	end

	// ==============================
	// outputs
	// ==============================
	assign scan_en = in_run | (state_q == CALIBRATE);
	assign count_en = (state_q == SELECT_PART);
	// index points at the line to come, so rdata is ready
	assign addr = idx_q;
	assign wdata = line;
	assign wr = part_line & teach_mode & room;
	assign part_ok = ok_q;
	assign status.state = state_q;
	assign status.part = part_q;

endmodule

//--- inspect_pkg.sv
// ==============================
// run states and panel-side bundles
// state codes show directly on a hex digit
// ==============================
`include "inspect_consts.svh"

package inspect_pkg;

	typedef logic [3:0] part_num_t;

	// one extra count so a full profile is visible
	localparam int PROF_AW = $clog2(`PROFILE_DEPTH + 1);
	typedef logic [PROF_AW-1:0] prof_addr_t;

	typedef enum logic [3:0] {
		SELECT_PART  = 4'd0,
		WAIT_START   = 4'd1,
		CALIBRATE    = 4'd2,
		SEEK_TEACH   = 4'd3,
		TEACH        = 4'd4,
		SEEK_INSPECT = 4'd5,
		INSPECT      = 4'd6
	} inspect_state_e;

	// buttons after debounce
	typedef struct packed {
		logic start;
		logic back;
		part_num_t count;
	} panel_cmd_t;

	// what the display needs from the controller
	typedef struct packed {
		inspect_state_e state;
		part_num_t part;
	} ctrl_status_t;

endpackage

//--- panel_display.sv
// ==============================
// digits are active low, segment a in bit 0
// ledg keeps the last line until the next one
// ==============================
`timescale 1ns/1ps
`include "inspect_consts.svh"

module panel_display (
	input  logic                      CLOCK_50,
	input  logic                      rst_n,
	input  inspect_pkg::part_num_t    count,
	input  inspect_pkg::ctrl_status_t status,
	input  ccd_pkg::scan_line_u       line,
	input  logic                      line_valid,
	output logic [6:0]                hex0,
	output logic [6:0]                hex1,
	output logic [6:0]                hex3,
	output logic [`LED_ZONES-1:0]     ledg
);

	// hex font, gfedcba
	function automatic logic [6:0] seg7(input logic [3:0] digit);
		case (digit)
			4'h0: seg7 = 7'b1000000;
			4'h1: seg7 = 7'b1111001;
			4'h2: seg7 = 7'b0100100;
			4'h3: seg7 = 7'b0110000;
			4'h4: seg7 = 7'b0011001;
			4'h5: seg7 = 7'b0010010;
			4'h6: seg7 = 7'b0000010;
			4'h7: seg7 = 7'b1111000;
			4'h8: seg7 = 7'b0000000;
			4'h9: seg7 = 7'b0010000;
			4'ha: seg7 = 7'b0001000;
			4'hb: seg7 = 7'b0000011;
			4'hc: seg7 = 7'b1000110;
			4'hd: seg7 = 7'b0100001;
			4'he: seg7 = 7'b0000110;
			default: seg7 = 7'b0001110;
		endcase
	endfunction

	assign hex0 = seg7(count);
	assign hex1 = seg7(status.part);
	assign hex3 = seg7(status.state);

	// any lit pixel lights its zone
	always_ff @(posedge CLOCK_50) begin
		if (!rst_n) begin
			ledg <= '0;
		end else if (line_valid) begin
			for (int z = 0; z < `LED_ZONES; z++) begin
				ledg[z] <= |line.zones[z];
			end
		end
	end

endmodule

//--- panel_input.sv
// ==============================
// active-low buttons sampled by a single register
// pulses come DEBOUNCE_CYCLES+1 cycles after a press
// ==============================
`timescale 1ns/1ps
`include "inspect_consts.svh"

module panel_input (
	input  logic                    CLOCK_50,
	input  logic                    rst_n,
	input  logic [2:0]              button,
	input  logic                    count_en,
	output inspect_pkg::panel_cmd_t cmd
);
	import inspect_pkg::*;

	localparam int CW = $clog2(`DEBOUNCE_CYCLES + 1);

	logic [2:0] btn_q;
	logic [2:0] level_q;
	logic [2:0][CW-1:0] stable_q;
	logic [2:0] fall_q;
	part_num_t count_q;

	// ==============================
	// one debounce counter per button
	// ==============================
	always_ff @(posedge CLOCK_50) begin
		if (!rst_n) begin
			btn_q <= '1;
			level_q <= '1;
			stable_q <= '0;
			fall_q <= '0;
		end else begin
			btn_q <= button;
			for (int i = 0; i < 3; i++) begin
				fall_q[i] <= 1'b0;
				if (btn_q[i] == level_q[i]) begin
					// bounced back so the count restarts
					stable_q[i] <= '0;
				end else if (stable_q[i] == CW'(`DEBOUNCE_CYCLES - 1)) begin
					level_q[i] <= btn_q[i];
					stable_q[i] <= '0;
					// only the press counts
					fall_q[i] <= ~btn_q[i];
				end else begin
					stable_q[i] <= stable_q[i] + 1'b1;
				end
			end
		end
	end

	// part counter wrapping mod 16
	always_ff @(posedge CLOCK_50) begin
		if (!rst_n) begin
			count_q <= '0;
		end else if (count_en && fall_q[0]) begin
			count_q <= count_q + 1'b1;
		end else if (count_en && fall_q[1]) begin
			count_q <= count_q - 1'b1;
		end
	end

	assign cmd.start = fall_q[2];
	assign cmd.back = fall_q[1];
	assign cmd.count = count_q;

	a_no_overlap: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
		!(cmd.start && cmd.back));

endmodule

//--- part_inspector.sv
// ==============================
// top level, buttons and sensor pins are asynchronous
// ==============================
`timescale 1ns/1ps
`include "inspect_consts.svh"

module part_inspector (
	input  logic                  CLOCK_50,
	input  logic                  rst_n,
	input  logic [2:0]            button,
	input  ccd_pkg::ccd_pins_t    ccd,
	output logic [6:0]            hex0,
	output logic [6:0]            hex1,
	output logic [6:0]            hex3,
	output logic [`LED_ZONES-1:0] ledg,
	output logic                  part_ok
);
	import ccd_pkg::*;
	import inspect_pkg::*;

	panel_cmd_t cmd;
	logic count_en;
	logic scan_en;
	scan_line_u line;
	logic line_valid;
	prof_addr_t addr;
	scan_line_u wdata;
	logic wr;
	scan_line_u rdata;
	ctrl_status_t status;

	ccd_reader u_reader (
		.CLOCK_50   (CLOCK_50),
		.rst_n      (rst_n),
		.ccd        (ccd),
		.scan_en    (scan_en),
		.line       (line),
		.line_valid (line_valid)
	);

	panel_input u_panel (
		.CLOCK_50 (CLOCK_50),
		.rst_n    (rst_n),
		.button   (button),
		.count_en (count_en),
		.cmd      (cmd)
	);

	profile_mem u_mem (
		.CLOCK_50 (CLOCK_50),
		.addr     (addr),
		.wdata    (wdata),
		.wr       (wr),
		.rdata    (rdata)
	);

	inspect_ctrl u_ctrl (
		.CLOCK_50   (CLOCK_50),
		.rst_n      (rst_n),
		.cmd        (cmd),
		.line       (line),
		.line_valid (line_valid),
		.rdata      (rdata),
		.scan_en    (scan_en),
		.count_en   (count_en),
		.addr       (addr),
		.wdata      (wdata),
		.wr         (wr),
		.part_ok    (part_ok),
		.status     (status)
	);

	panel_display u_display (
		.CLOCK_50   (CLOCK_50),
		.rst_n      (rst_n),
		.count      (cmd.count),
		.status     (status),
		.line       (line),
		.line_valid (line_valid),
		.hex0       (hex0),
		.hex1       (hex1),
		.hex3       (hex3),
		.ledg       (ledg)
	);

endmodule

//--- profile_mem.sv
// ==============================
// no reset, contents are undefined until taught
// read is registered, rdata trails addr by one cycle
// ==============================
`timescale 1ns/1ps
`include "inspect_consts.svh"

module profile_mem (
	input  logic                    CLOCK_50,
	input  inspect_pkg::prof_addr_t addr,
	input  ccd_pkg::scan_line_u     wdata,
	input  logic                    wr,
	output ccd_pkg::scan_line_u     rdata
);
	import ccd_pkg::*;

	localparam int IW = $clog2(`PROFILE_DEPTH);

	scan_line_u mem [`PROFILE_DEPTH];
	logic [IW-1:0] idx;

	// top address bit only flags a full profile
	assign idx = addr[IW-1:0];

	always_ff @(posedge CLOCK_50) begin
		if (wr) begin
			mem[idx] <= wdata;
		end
		// old data on a same-cycle write
		rdata <= mem[idx];
	end

	// controller must stop writing once the profile is full
	a_addr_range: assert property (@(posedge CLOCK_50)
		wr |-> (addr < `PROFILE_DEPTH));

endmodule

//--- run.sh
#!/bin/sh
# build and run the part inspector testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
	--top-module tb_part_inspector -f vlog.f
out=$(./obj_dir/Vtb_part_inspector 2>&1) || true
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qF '*** TEST PASSED ***'; then
	exit 0
else
	echo "simulation did not pass"
	exit 1
fi

//--- tb_part_inspector.sv
// ==============================
// directed tests, the sensor is modelled pin by pin
// one line takes about 140 cycles, one press 16
// ==============================
`timescale 1ns/1ps
`include "inspect_consts.svh"

module tb_part_inspector;
	import ccd_pkg::*;
	import inspect_pkg::*;

	localparam int BTN_UP = 0;
	localparam int BTN_DOWN = 1;
	localparam int BTN_START = 2;
	localparam int WAIT_LIMIT = 2000;
	localparam int LINE_GAP = 10;
	localparam int ZP = `SCAN_PIXELS / `LED_ZONES;

	// active-low hex font, gfedcba
	localparam logic [6:0] FONT [16] = '{
		7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
		7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e
	};

	logic CLOCK_50;
	logic rst_n;
	logic [2:0] button;
	ccd_pins_t ccd;
	logic [6:0] hex0;
	logic [6:0] hex1;
	logic [6:0] hex3;
	logic [`LED_ZONES-1:0] ledg;
	logic part_ok;

	logic [63:0] rng_q;
	scan_line_u blank;
	// lines of the taught part, and of the part under test
	scan_line_u taught [3];
	scan_line_u run_lines [3];

	part_inspector UUT (
		.CLOCK_50 (CLOCK_50),
		.rst_n    (rst_n),
		.button   (button),
		.ccd      (ccd),
		.hex0     (hex0),
		.hex1     (hex1),
		.hex3     (hex3),
		.ledg     (ledg),
		.part_ok  (part_ok)
	);

	initial begin
		CLOCK_50 = 1'b0;
		forever #20 CLOCK_50 = ~CLOCK_50;
	end

	// ==============================
	// reporting and compares
	// ==============================
	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("*** TEST FAILED ***");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic check_state(input string name, input inspect_state_e exp);
		if (hex3 !== FONT[exp])
			stop_on_error($sformatf("ERR %s: state expected %s (hex3 %b), actual hex3 %b",
				name, exp.name(), FONT[exp], hex3));
	endtask

	task automatic check_digit(input string name, input part_num_t exp, input logic [6:0] act);
		if (act !== FONT[exp])
			stop_on_error($sformatf("ERR %s: digit expected %h (%b), actual %b",
				name, exp, FONT[exp], act));
	endtask

	task automatic check_ledg(input string name, input logic [`LED_ZONES-1:0] exp);
		if (ledg !== exp)
			stop_on_error($sformatf("ERR %s: ledg expected %b, actual %b", name, exp, ledg));
	endtask

	task automatic check_ok(input string name, input logic exp);
		if (part_ok !== exp)
			stop_on_error($sformatf("ERR %s: part_ok expected %b, actual %b", name, exp, part_ok));
	endtask

	// ==============================
	// stimulus helpers
	// ==============================
	function automatic logic [63:0] xorshift(input logic [63:0] s);
		logic [63:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 7);
		x = x ^ (x << 17);
		return x;
	endfunction

	// random pixels, then whole zones cleared so some LEDs stay dark
	task automatic random_line(output scan_line_u l);
		rng_q = xorshift(rng_q);
		l.flat = rng_q[`SCAN_PIXELS-1:0];
		rng_q = xorshift(rng_q);
		for (int z = 0; z < `LED_ZONES; z++) begin
			if (!rng_q[z]) l.zones[z] = '0;
		end
		// never blank, or it would end the run
		if (l.flat == '0) l.flat[0] = 1'b1;
	endtask

	// expected LED bar, OR over each run of ZP pixels
	function automatic logic [`LED_ZONES-1:0] zone_or(input scan_line_u l);
		logic [`LED_ZONES-1:0] acc;
		acc = '0;
		for (int p = 0; p < `SCAN_PIXELS; p++) begin
			acc[p / ZP] = acc[p / ZP] | l.flat[p];
		end
		return acc;
	endfunction

	// hold low 8 cycles, then 8 released so the release debounce settles
	task automatic press(input int b);
		@(negedge CLOCK_50);
		button[b] = 1'b0;
		repeat (8) @(negedge CLOCK_50);
		button[b] = 1'b1;
		repeat (8) @(negedge CLOCK_50);
	endtask

	// SH pulse, then one mclk edge per pixel, pixel 0 first
	task automatic send_line(input scan_line_u l);
		@(negedge CLOCK_50);
		ccd.sh = 1'b1;
		repeat (2) @(negedge CLOCK_50);
		ccd.sh = 1'b0;
		repeat (2) @(negedge CLOCK_50);
		for (int i = 0; i < `SCAN_PIXELS; i++) begin
			ccd.data = l.flat[i];
			ccd.mclk = ~ccd.mclk;
			repeat (2) @(negedge CLOCK_50);
		end
		ccd.data = 1'b0;
		repeat (LINE_GAP) @(negedge CLOCK_50);
	endtask

	task automatic wait_state(input string name, input inspect_state_e exp);
		int n;
		n = 0;
		while (hex3 !== FONT[exp] && n < WAIT_LIMIT) begin
			@(negedge CLOCK_50);
			n++;
		end
		if (hex3 !== FONT[exp])
			stop_on_error($sformatf("%s: timed out waiting for state %s", name, exp.name()));
	endtask

	// ==============================
	// directed tests
	// ==============================
	task automatic test_reset();
		check_state("reset", SELECT_PART);
		check_ok("reset", 1'b0);
		check_ledg("reset", '0);
	endtask

	task automatic test_counter();
		part_num_t exp;
		exp = 4'd0;
		for (int i = 0; i < 3; i++) begin
			press(BTN_UP);
			exp = exp + 4'd1;
			check_digit("count_up", exp, hex0);
		end
		// down past zero wraps to F
		for (int i = 0; i < 4; i++) begin
			press(BTN_DOWN);
			exp = exp - 4'd1;
			check_digit("count_down", exp, hex0);
		end
		press(BTN_UP);
		exp = exp + 4'd1;
		check_digit("count_wrap", exp, hex0);
		press(BTN_START);
		wait_state("count_start", WAIT_START);
		// counter frozen outside part selection
		press(BTN_UP);
		check_digit("count_frozen", exp, hex0);
	endtask

	task automatic test_back_and_capture();
		press(BTN_DOWN);
		wait_state("back", SELECT_PART);
		check_digit("back_count", 4'd0, hex0);
		press(BTN_UP);
		press(BTN_UP);
		check_digit("capture_count", 4'd2, hex0);
		press(BTN_START);
		wait_state("capture", WAIT_START);
		check_digit("capture_part", 4'd2, hex1);
		press(BTN_DOWN);
		wait_state("capture_back", SELECT_PART);
		press(BTN_DOWN);
		press(BTN_DOWN);
		check_digit("capture_reset_count", 4'd0, hex0);
	endtask

	task automatic test_teach();
		press(BTN_START);
		wait_state("teach_wait", WAIT_START);
		check_digit("teach_part", 4'd0, hex1);
		press(BTN_START);
		wait_state("teach_cal", CALIBRATE);
		send_line(blank);
		wait_state("teach_seek", SEEK_TEACH);
		// background again, still seeking
		send_line(blank);
		check_state("teach_skip", SEEK_TEACH);
		for (int i = 0; i < 3; i++) begin
			random_line(taught[i]);
			send_line(taught[i]);
			check_state("teach_line", TEACH);
			check_ledg("teach_ledg", zone_or(taught[i]));
		end
		send_line(blank);
		wait_state("teach_end", SELECT_PART);
		check_ledg("teach_end_ledg", '0);
	endtask

	// counter must already hold the part to inspect
	task automatic test_inspect(input string name);
		logic exp_ok;
		exp_ok = 1'b1;
		for (int i = 0; i < 3; i++) begin
			if (run_lines[i].flat != taught[i].flat) exp_ok = 1'b0;
		end
		press(BTN_START);
		wait_state(name, WAIT_START);
		press(BTN_START);
		wait_state(name, CALIBRATE);
		send_line(blank);
		wait_state(name, SEEK_INSPECT);
		check_ok(name, 1'b1);
		for (int i = 0; i < 3; i++) begin
			send_line(run_lines[i]);
			check_state(name, INSPECT);
		end
		send_line(blank);
		wait_state(name, SELECT_PART);
		check_ok(name, exp_ok);
	endtask

	// ==============================
	// main sequence
	// ==============================
	initial begin
		rst_n = 1'b0;
		button = '1;
		ccd = '0;
		rng_q = 64'd40694;
		blank.flat = '0;
		repeat (10) @(negedge CLOCK_50);
		rst_n = 1'b1;
		@(negedge CLOCK_50);
		test_reset();
		test_counter();
		test_back_and_capture();
		test_teach();
		press(BTN_UP);
		check_digit("select_part_1", 4'd1, hex0);
		run_lines = taught;
		test_inspect("inspect_match");
		// one pixel off in the middle line
		run_lines = taught;
		run_lines[1].flat[5] = ~run_lines[1].flat[5];
		test_inspect("inspect_mismatch");
		$display("*** TEST PASSED ***");
		$finish;
	end

	// guards against a hang outside the waits
	initial begin
		repeat (200000) @(posedge CLOCK_50);
		stop_on_error("watchdog: simulation ran far longer than the tests need");
	end

endmodule

//--- vlog.f
+incdir+.
ccd_pkg.sv
inspect_pkg.sv
ccd_reader.sv
panel_input.sv
profile_mem.sv
inspect_ctrl.sv
panel_display.sv
part_inspector.sv
tb_part_inspector.sv
